// File: flist.f
rtl/audio_pkg.sv
rtl/audio_regs.sv
rtl/sample_fifo.sv
rtl/sample_pacer.sv
rtl/i2s_serializer.sv
rtl/audio_top.sv
testbench/audio_sva.sv
testbench/audio_checker.sv
testbench/tb_audio.sv

// File: run.sh
#!/bin/sh
# Builds and runs the audio testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_audio -f flist.f \
	-Mdir obj_dir -o tb_audio_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "Build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/tb_audio_sim > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"

if grep -q "Test FAILED" "$SIM_LOG"; then
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "Simulation ended with status $sim_status"
	exit 1
fi
exit 0

// File: testbench/tb_audio.sv
`timescale 1ns/1ps
`default_nettype none

module tb_audio;

	localparam int FIFO_DEPTH = 16;
	localparam int MAX_DIVIDER = 300;
	// Roughly 100 sample periods are used by all phases together.
	localparam int TOTAL_PERIODS = 120;
	localparam int TIMEOUT_NS = (TOTAL_PERIODS * MAX_DIVIDER + 4000) * 20;

	logic clock = 1'b0;
	logic arst_n;
	logic request;
	logic rw;
	audio_pkg::bus_addr_t address;
	audio_pkg::bus_data_t wdata;
	audio_pkg::bus_data_t rdata;
	logic ready;
	logic interrupt;
	logic bclk;
	logic lrclk;
	logic sdata;
	logic final_check;
	int errors;
	int frames;
	int queue_len;

	always #10 clock = ~clock;

	audio_top #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) dut0 (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.i_request(request),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.o_rdata(rdata),
		.o_ready(ready),
		.o_interrupt(interrupt),
		.o_bclk(bclk),
		.o_lrclk(lrclk),
		.o_sdata(sdata)
	);

	audio_checker #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) chk0 (
		.i_clock(clock),
		.i_arst_n(arst_n),
		.i_rw(rw),
		.i_address(address),
		.i_wdata(wdata),
		.i_rdata(rdata),
		.i_ready(ready),
		.i_interrupt(interrupt),
		.i_bclk(bclk),
		.i_lrclk(lrclk),
		.i_sdata(sdata),
		.i_final(final_check),
		.o_errors(errors),
		.o_frames(frames),
		.o_queue_len(queue_len)
	);

	task automatic bus_access(input logic write, input audio_pkg::bus_addr_t addr,
			input audio_pkg::bus_data_t data);
		@(posedge clock);
		request <= 1'b1;
		rw <= write;
		address <= addr;
		wdata <= data;
		do @(posedge clock); while (!ready);
		request <= 1'b0;
		while (ready)
			@(posedge clock);
	endtask

	task automatic write_reg(input audio_pkg::bus_addr_t addr, input audio_pkg::bus_data_t data);
		bus_access(1'b1, addr, data);
	endtask

	// Read data is compared by the checker.
	task automatic read_reg(input audio_pkg::bus_addr_t addr);
		bus_access(1'b0, addr, '0);
	endtask

	task automatic wait_frames(input int count);
		int target;
		target = frames + count;
		while (frames < target)
			@(posedge clock);
	endtask

	task automatic wait_drained();
		while (queue_len != 0)
			@(posedge clock);
	endtask

	// Zero is reserved for silence frames.
	function automatic audio_pkg::bus_data_t random_sample();
		audio_pkg::bus_data_t s;
		do s = $urandom; while (s == '0);
		return s;
	endfunction

	initial begin
		#(TIMEOUT_NS);
		$display("Watchdog expired before the tests finished");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		int count;
		arst_n = 1'b0;
		request = 1'b0;
		rw = 1'b0;
		address = '0;
		wdata = '0;
		final_check = 1'b0;
		void'($urandom(79));
		repeat (3) @(posedge clock);
		arst_n <= 1'b1;
		@(posedge clock);

		// Divider writes, some of them below the minimum.
		for (int i = 0; i < 8; i++) begin
			write_reg(audio_pkg::ADDR_DIVIDER, $urandom_range(20, MAX_DIVIDER));
			read_reg(audio_pkg::ADDR_DIVIDER);
			wait_frames(3);
		end

		// Unmapped addresses read as zero.
		read_reg(audio_pkg::bus_addr_t'($urandom_range(3, 15)));

		// Short bursts of samples with a fill-level read after each.
		write_reg(audio_pkg::ADDR_DIVIDER, $urandom_range(66, 120));
		for (int b = 0; b < 5; b++) begin
			count = $urandom_range(1, 6);
			for (int k = 0; k < count; k++)
				write_reg(audio_pkg::ADDR_SAMPLE, random_sample());
			read_reg(audio_pkg::ADDR_SAMPLE);
			wait_drained();
		end

		// Overfill the FIFO so that the last writes are held back.
		write_reg(audio_pkg::ADDR_DIVIDER, MAX_DIVIDER);
		for (int k = 0; k < FIFO_DEPTH + 4; k++)
			write_reg(audio_pkg::ADDR_SAMPLE, random_sample());
		read_reg(audio_pkg::ADDR_SAMPLE);
		wait_drained();

		// Underflow counting. Accesses start right after a frame ends, far from the next tick.
		write_reg(audio_pkg::ADDR_DIVIDER, 200);
		wait_frames(3);
		write_reg(audio_pkg::ADDR_UNDERFLOW, '0);
		read_reg(audio_pkg::ADDR_UNDERFLOW);
		wait_frames($urandom_range(2, 6));
		read_reg(audio_pkg::ADDR_UNDERFLOW);
		write_reg(audio_pkg::ADDR_UNDERFLOW, '0);
		read_reg(audio_pkg::ADDR_UNDERFLOW);

		@(posedge clock);
		final_check <= 1'b1;
		repeat (2) @(posedge clock);
		$display("Errors counted: %0d", errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/audio_checker.sv
`timescale 1ns/1ps
`default_nettype none

module audio_checker #(
	parameter int FIFO_DEPTH = 16
)(
	input wire i_clock,
	input wire i_arst_n,
	input wire i_rw,
	input wire audio_pkg::bus_addr_t i_address,
	input wire audio_pkg::bus_data_t i_wdata,
	input wire audio_pkg::bus_data_t i_rdata,
	input wire i_ready,
	input wire i_interrupt,
	input wire i_bclk,
	input wire i_lrclk,
	input wire i_sdata,
	input wire i_final,
	output int o_errors,
	output int o_frames,
	output int o_queue_len
);

	localparam int HALF = FIFO_DEPTH / 2;
	// Marks a bit counter that waits for the next frame start.
	localparam int IDLE_BITS = 99;

	logic [31:0] expected_q [$];
	logic [31:0] frame_bits;
	logic prev_ready;
	logic prev_bclk;
	logic prev_lrclk;
	logic have_start;
	logic final_done;
	audio_pkg::divider_t exp_div;
	int bit_count;
	int cycle;
	int last_start;
	int skip_spacing;
	int zero_frames;
	int irq_count;
	int crossings;
	int frames;
	int error_count = 0;

	task automatic report_value(input string name, input longint got, input longint expected);
		error_count++;
		$display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
	endtask

	task automatic check_access();
		int depth_now;
		depth_now = expected_q.size();
		if (i_rw) begin
			case (i_address)
				audio_pkg::ADDR_SAMPLE:
					expected_q.push_back(i_wdata);
				audio_pkg::ADDR_DIVIDER: begin
					if (i_wdata[15:0] < audio_pkg::MIN_DIVIDER)
						exp_div = audio_pkg::MIN_DIVIDER;
					else
						exp_div = i_wdata[15:0];
					// The period in progress and the next one may be irregular.
					skip_spacing = 2;
				end
				audio_pkg::ADDR_UNDERFLOW:
					zero_frames = 0;
				default: begin
				end
			endcase
		end else begin
			case (i_address)
				audio_pkg::ADDR_SAMPLE: begin
					if (i_rdata > audio_pkg::bus_data_t'(FIFO_DEPTH) ||
							int'(i_rdata) > depth_now || int'(i_rdata) < depth_now - 2) begin
						error_count++;
						$display("ERR %0t o_rdata fill level got %0d expected %0d to %0d",
							$time, i_rdata, depth_now - 2, depth_now);
					end
				end
				audio_pkg::ADDR_DIVIDER:
					if (i_rdata != audio_pkg::bus_data_t'(exp_div))
						report_value("o_rdata divider", i_rdata, exp_div);
				audio_pkg::ADDR_UNDERFLOW:
					if (i_rdata != audio_pkg::bus_data_t'(zero_frames))
						report_value("o_rdata underflow count", i_rdata, zero_frames);
				default:
					if (i_rdata != '0)
						report_value("o_rdata unmapped", i_rdata, 0);
			endcase
		end
	endtask

	task automatic finish_frame();
		int level_before;
		logic [31:0] head;
		frames++;
		if (frame_bits == '0) begin
			zero_frames++;
		end else if (expected_q.size() == 0) begin
			error_count++;
			$display("ERR %0t o_sdata frame %h arrived with no sample queued", $time, frame_bits);
		end else begin
			level_before = expected_q.size();
			head = expected_q.pop_front();
			if (head != frame_bits)
				report_value("o_sdata frame", frame_bits, head);
			if (level_before > HALF && level_before - 1 <= HALF)
				crossings++;
		end
	endtask

	// All inputs are sampled on the system clock, so edges of the I2S lines are
	// found by comparing with the previous sample.
	always @(posedge i_clock) begin
		if (!i_arst_n) begin
			prev_ready = 1'b0;
			prev_bclk = 1'b0;
			prev_lrclk = 1'b1;
			have_start = 1'b0;
			final_done = 1'b0;
			exp_div = audio_pkg::DEFAULT_DIVIDER;
			bit_count = IDLE_BITS;
			frame_bits = '0;
			cycle = 0;
			last_start = 0;
			skip_spacing = 0;
			zero_frames = 0;
			irq_count = 0;
			crossings = 0;
			frames = 0;
		end else begin
			cycle++;
			if (i_ready && !prev_ready)
				check_access();
			if (i_interrupt)
				irq_count++;
			// A falling word select starts a frame.
			if (prev_lrclk && !i_lrclk) begin
				if (have_start) begin
					if (skip_spacing > 0)
						skip_spacing--;
					else if (cycle - last_start != int'(exp_div))
						report_value("o_lrclk frame spacing", cycle - last_start, exp_div);
				end
				have_start = 1'b1;
				last_start = cycle;
				bit_count = 0;
				frame_bits = '0;
			end
			// The first rising edge of a frame carries the one-bit delay slot.
			if (i_bclk && !prev_bclk && bit_count != IDLE_BITS) begin
				if (bit_count > 0)
					frame_bits = {frame_bits[30:0], i_sdata};
				bit_count++;
				if (bit_count == 33) begin
					finish_frame();
					bit_count = IDLE_BITS;
				end
			end
			if (i_final && !final_done) begin
				final_done = 1'b1;
				if (irq_count != crossings)
					report_value("o_interrupt count", irq_count, crossings);
				if (expected_q.size() != 0) begin
					error_count++;
					$display("ERR %0t samples were written but never played", $time);
				end
			end
			prev_ready = i_ready;
			prev_bclk = i_bclk;
			prev_lrclk = i_lrclk;
		end
		o_errors <= error_count;
		o_frames <= frames;
		o_queue_len <= expected_q.size();
	end

endmodule

`default_nettype wire

// File: testbench/audio_sva.sv
`timescale 1ns/1ps
`default_nettype none

module audio_sva (
	input wire i_clock,
	input wire i_arst_n,
	input wire i_request,
	input wire i_ready,
	input wire i_bclk,
	input wire i_lrclk,
	input wire i_interrupt
);

	// The controller may only finish an access that the CPU asked for.
	ready_needs_request: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		$rose(i_ready) |-> $past(i_request)
	) else $error("o_ready rose without a pending request");

	// Word select moves on the falling bit-clock edge only.
	lrclk_on_low_bclk: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		$changed(i_lrclk) |-> !i_bclk
	) else $error("word select changed while the bit clock was high");

	interrupt_single_cycle: assert property (
		@(posedge i_clock) disable iff (!i_arst_n)
		i_interrupt |=> !i_interrupt
	) else $error("interrupt stayed high for two cycles");

endmodule

bind audio_top audio_sva sva0 (
	.i_clock(i_clock),
	.i_arst_n(i_arst_n),
	.i_request(i_request),
	.i_ready(o_ready),
	.i_bclk(o_bclk),
	.i_lrclk(o_lrclk),
	.i_interrupt(o_interrupt)
);

`default_nettype wire

// File: rtl/audio_top.sv
`timescale 1ns/1ps
`default_nettype none

module audio_top #(
	parameter int FIFO_DEPTH = audio_pkg::DEFAULT_FIFO_DEPTH
)(
	input wire i_clock,
	input wire i_arst_n,

	// CPU bus.
	input wire i_request,
	input wire i_rw,
	input wire audio_pkg::bus_addr_t i_address,
	input wire audio_pkg::bus_data_t i_wdata,
	output audio_pkg::bus_data_t o_rdata,
	output logic o_ready,
	output logic o_interrupt,

	// I2S output.
	output logic o_bclk,
	output logic o_lrclk,
	output logic o_sdata
);

	localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);

	wire fifo_write;
	wire audio_pkg::stereo_sample_t fifo_sample;
	wire fifo_full;
	wire fifo_empty;
	wire [LEVEL_W-1:0] fifo_level;
	wire audio_pkg::stereo_sample_t fifo_head;
	wire fifo_pop;
	wire audio_pkg::divider_t divider;
	wire audio_pkg::underflow_count_t underflow_count;
	wire underflow_clear;
	wire frame_req;
	wire frame_ack;
	wire audio_pkg::stereo_sample_t frame_sample;

	audio_regs #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_regs (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.o_rdata(o_rdata),
		.o_ready(o_ready),
		.o_fifo_write(fifo_write),
		.o_fifo_sample(fifo_sample),
		.i_fifo_full(fifo_full),
		.i_fifo_level(fifo_level),
		.o_divider(divider),
		.i_underflow_count(underflow_count),
		.o_underflow_clear(underflow_clear)
	);

	sample_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) u_fifo (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_write(fifo_write),
		.i_sample(fifo_sample),
		.i_pop(fifo_pop),
		.o_head(fifo_head),
		.o_empty(fifo_empty),
		.o_full(fifo_full),
		.o_level(fifo_level),
		.o_interrupt(o_interrupt)
	);

	sample_pacer u_pacer (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_divider(divider),
		.i_head(fifo_head),
		.i_empty(fifo_empty),
		.o_pop(fifo_pop),
		.i_underflow_clear(underflow_clear),
		.o_underflow_count(underflow_count),
		.o_req(frame_req),
		.o_sample(frame_sample),
		.i_ack(frame_ack)
	);

	i2s_serializer u_serializer (
		.i_clock(i_clock),
		.i_arst_n(i_arst_n),
		.i_req(frame_req),
		.i_sample(frame_sample),
		.o_ack(frame_ack),
		.o_bclk(o_bclk),
		.o_lrclk(o_lrclk),
		.o_sdata(o_sdata)
	);

endmodule

`default_nettype wire

// File: rtl/i2s_serializer.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_serializer (
	input wire i_clock,
	input wire i_arst_n,
	input wire i_req,
	input wire audio_pkg::stereo_sample_t i_sample,
	output logic o_ack,
	output logic o_bclk,
	output logic o_lrclk,
	output logic o_sdata
);

	// Phase counts clocks from the frame start. Phases 64 and 65 carry the
	// right LSB, which trails the frame by one bit because of the I2S delay.
	localparam logic [6:0] FRAME_LAST = 7'd63;
	localparam logic [6:0] RIGHT_START = 7'd32;
	localparam logic [6:0] TAIL_END = 7'd66;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACKNOWLEDGE,
		ST_SHIFT
	} serializer_state_t;

	serializer_state_t state;
	logic [6:0] phase;
	logic [6:0] next_phase;
	logic [31:0] shift_reg;
	logic load;
	logic bit_edge;

	assign next_phase = phase + 7'd1;
	assign load = (state == ST_IDLE) && i_req && !o_ack;

	// Even phases start a bit period, which is where the bit clock falls.
	assign bit_edge = (state != ST_ACKNOWLEDGE) && (phase != TAIL_END) && !next_phase[0];

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			o_ack <= 1'b0;
		end else begin
			if (o_ack && !i_req)
				o_ack <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (load) begin
						o_ack <= 1'b1;
						state <= ST_ACKNOWLEDGE;
					end
				end
				ST_ACKNOWLEDGE:
					state <= ST_SHIFT;
				ST_SHIFT: begin
					if (phase == FRAME_LAST)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			phase <= TAIL_END;
			o_bclk <= 1'b0;
			o_lrclk <= 1'b1;
			o_sdata <= 1'b0;
		end else if (state == ST_ACKNOWLEDGE) begin
			// Word select drops for the left word; the first bit slot is the delay slot.
			phase <= '0;
			o_bclk <= 1'b0;
			o_lrclk <= 1'b0;
			o_sdata <= 1'b0;
		end else if (phase != TAIL_END) begin
			phase <= next_phase;
			o_bclk <= next_phase[0];
			o_lrclk <= (next_phase >= RIGHT_START);
			if (bit_edge)
				o_sdata <= (next_phase == TAIL_END) ? 1'b0 : shift_reg[31];
		end
	end

	always_ff @(posedge i_clock) begin
		if (load)
			shift_reg <= i_sample;
		else if (bit_edge)
			shift_reg <= {shift_reg[30:0], 1'b0};
	end

endmodule

`default_nettype wire

// File: rtl/sample_pacer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_pacer (
	input wire i_clock,
	input wire i_arst_n,
	input wire audio_pkg::divider_t i_divider,
	input wire audio_pkg::stereo_sample_t i_head,
	input wire i_empty,
	output logic o_pop,
	input wire i_underflow_clear,
	output audio_pkg::underflow_count_t o_underflow_count,
	output logic o_req,
	output audio_pkg::stereo_sample_t o_sample,
	input wire i_ack
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_REQUEST,
		ST_RELEASE
	} pacer_state_t;

	pacer_state_t state;
	audio_pkg::divider_t period_count;
	logic tick;
	logic underflow;

	// The compare tolerates a divider that shrinks mid-period.
	assign tick = (period_count >= i_divider - audio_pkg::divider_t'(1));

	// A tick is lost when the FIFO is empty or the last handover is still open.
	assign underflow = tick && ((state != ST_IDLE) || i_empty);

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			period_count <= '0;
		else
			period_count <= tick ? '0 : period_count + 1'b1;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n)
			o_underflow_count <= '0;
		else if (i_underflow_clear)
			o_underflow_count <= underflow ? 16'd1 : 16'd0;
		else if (underflow && (o_underflow_count != '1))
			o_underflow_count <= o_underflow_count + 1'b1;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			o_pop <= 1'b0;
			o_req <= 1'b0;
		end else begin
			o_pop <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (tick) begin
						o_pop <= !i_empty;
						o_req <= 1'b1;
						state <= ST_REQUEST;
					end
				end
				ST_REQUEST: begin
					if (i_ack) begin
						o_req <= 1'b0;
						state <= ST_RELEASE;
					end
				end
				ST_RELEASE: begin
					if (!i_ack)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Silence goes out as an all-zero sample.
	always_ff @(posedge i_clock) begin
		if (tick && (state == ST_IDLE))
			o_sample <= i_empty ? '0 : i_head;
	end

endmodule

`default_nettype wire

// File: rtl/sample_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sample_fifo #(
	parameter int FIFO_DEPTH = audio_pkg::DEFAULT_FIFO_DEPTH
)(
	input wire i_clock,
	input wire i_arst_n,
	input wire i_write,
	input wire audio_pkg::stereo_sample_t i_sample,
	input wire i_pop,
	output audio_pkg::stereo_sample_t o_head,
	output logic o_empty,
	output logic o_full,
	output logic [$clog2(FIFO_DEPTH + 1)-1:0] o_level,
	output logic o_interrupt
);

	localparam int PTR_W = $clog2(FIFO_DEPTH);
	localparam int LEVEL_W = $clog2(FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_INDEX = PTR_W'(FIFO_DEPTH - 1);
	localparam logic [LEVEL_W-1:0] HALF_LEVEL = LEVEL_W'(FIFO_DEPTH / 2);

	audio_pkg::stereo_sample_t mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic push;
	logic pop;
	logic [1:0] above_half;

	assign push = i_write && !o_full;
	assign pop = i_pop && !o_empty;

	assign o_empty = (o_level == '0);
	assign o_full = (o_level == LEVEL_W'(FIFO_DEPTH));
	assign o_head = mem[rd_ptr];

	always_ff @(posedge i_clock) begin
		if (push)
			mem[wr_ptr] <= i_sample;
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			o_level <= '0;
		end else begin
			if (push)
				wr_ptr <= (wr_ptr == LAST_INDEX) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == LAST_INDEX) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: o_level <= o_level + 1'b1;
				2'b01: o_level <= o_level - 1'b1;
				default: o_level <= o_level;
			endcase
		end
	end

	// The interrupt fires once when the level falls to half full or below.
	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			above_half <= 2'b00;
			o_interrupt <= 1'b0;
		end else begin
			above_half <= {above_half[0], o_level > HALF_LEVEL};
			o_interrupt <= (above_half == 2'b10);
		end
	end

endmodule

`default_nettype wire

// File: rtl/audio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module audio_regs #(
	parameter int FIFO_DEPTH = audio_pkg::DEFAULT_FIFO_DEPTH
)(
	input wire i_clock,
	input wire i_arst_n,

	// CPU bus.
	input wire i_request,
	input wire i_rw,
	input wire audio_pkg::bus_addr_t i_address,
	input wire audio_pkg::bus_data_t i_wdata,
	output audio_pkg::bus_data_t o_rdata,
	output logic o_ready,

	// Sample FIFO write side.
	output logic o_fifo_write,
	output audio_pkg::stereo_sample_t o_fifo_sample,
	input wire i_fifo_full,
	input wire [$clog2(FIFO_DEPTH + 1)-1:0] i_fifo_level,

	// Pacer control and status.
	output audio_pkg::divider_t o_divider,
	input wire audio_pkg::underflow_count_t i_underflow_count,
	output logic o_underflow_clear
);

	typedef enum logic {
		ST_IDLE,
		ST_DONE
	} regs_state_t;

	regs_state_t state;
	audio_pkg::bus_data_t read_value;
	audio_pkg::divider_t requested_divider;
	logic accept;

	// Only the low half of a divider write is meaningful.
	assign requested_divider = audio_pkg::divider_t'(i_wdata);

	// A sample write to a full FIFO waits here until the pacer frees a slot.
	assign accept = (state == ST_IDLE) && i_request &&
		!(i_rw && (i_address == audio_pkg::ADDR_SAMPLE) && i_fifo_full);

	assign o_ready = (state == ST_DONE);

	always_comb begin
		case (i_address)
			audio_pkg::ADDR_SAMPLE:
				read_value = audio_pkg::bus_data_t'(i_fifo_level);
			audio_pkg::ADDR_DIVIDER:
				read_value = audio_pkg::bus_data_t'(o_divider);
			audio_pkg::ADDR_UNDERFLOW:
				read_value = audio_pkg::bus_data_t'(i_underflow_count);
			default:
				read_value = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state <= ST_IDLE;
			o_fifo_write <= 1'b0;
			o_underflow_clear <= 1'b0;
			o_divider <= audio_pkg::DEFAULT_DIVIDER;
		end else begin
			o_fifo_write <= 1'b0;
			o_underflow_clear <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (accept) begin
						state <= ST_DONE;
						if (i_rw) begin
							case (i_address)
								audio_pkg::ADDR_SAMPLE:
									o_fifo_write <= 1'b1;
								audio_pkg::ADDR_DIVIDER: begin
									// Shorter periods could not fit a whole frame.
									if (requested_divider < audio_pkg::MIN_DIVIDER)
										o_divider <= audio_pkg::MIN_DIVIDER;
									else
										o_divider <= requested_divider;
								end
								audio_pkg::ADDR_UNDERFLOW:
									o_underflow_clear <= 1'b1;
								default: begin
								end
							endcase
						end
					end
				end
				ST_DONE: begin
					if (!i_request)
						state <= ST_IDLE;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Read data and the sample word are captured with the accepted request.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_rdata <= i_rw ? '0 : read_value;
			o_fifo_sample <= audio_pkg::stereo_sample_t'(i_wdata);
		end
	end

endmodule

`default_nettype wire

// File: rtl/audio_pkg.sv
`default_nettype none

package audio_pkg;

	// One channel of PCM audio, two's complement.
	typedef logic [15:0] pcm_t;

	// Left sits in the upper half of the 32-bit word.
	typedef struct packed {
		pcm_t left;
		pcm_t right;
	} stereo_sample_t;

	typedef logic [3:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// Clocks per sample period.
	typedef logic [15:0] divider_t;

	// Sample periods that went out as silence.
	typedef logic [15:0] underflow_count_t;

	// Register map.
	localparam bus_addr_t ADDR_SAMPLE = 4'd0;
	localparam bus_addr_t ADDR_DIVIDER = 4'd1;
	localparam bus_addr_t ADDR_UNDERFLOW = 4'd2;

	localparam divider_t DEFAULT_DIVIDER = 16'd96;

	// One I2S frame is 64 clocks, and the pacer handover needs two more.
	localparam divider_t MIN_DIVIDER = 16'd66;

	localparam int DEFAULT_FIFO_DEPTH = 4096;

endpackage

`default_nettype wire
